/* gmii_rx_mac.f */
hw/gmii_rx_pkg.sv
hw/gmii_rx_framer.sv
hw/rx_packet_fifo.sv
hw/rx_frame_stats.sv
hw/gmii_rx_mac.sv
verification/gmii_rx_mac_tb.sv

/* Makefile */
SIM      := verilator
FLAGS    := --binary --timing --assert -j 0
TOP      := gmii_rx_mac_tb
FILELIST := gmii_rx_mac.f
PASS_MSG := PASS: all tests

SOURCES  := $(shell cat $(FILELIST))
BINARY   := obj_dir/V$(TOP)

.PHONY: all run lint clean

all: run

$(BINARY): $(FILELIST) $(SOURCES)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BINARY)
	./$(BINARY) | tee /dev/stderr | grep -q -F -x "$(PASS_MSG)"

lint:
	$(SIM) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir

/* verification/gmii_rx_mac_tb.sv */
// Runs AXIS_BYTES 4 with a 64-word FIFO; overflow is predicted only with out_ready held low
`default_nettype none

module gmii_rx_mac_tb;

	import gmii_rx_pkg::*;

	localparam int AXIS_BYTES      = 4;
	localparam int FIFO_DEPTH_LOG2 = 6;
	localparam int DEPTH           = 1 << FIFO_DEPTH_LOG2;
	localparam logic [15:0] SEED   = 16'd58564;
	localparam int WATCHDOG_MARGIN = 5000;
	// out_ready patterns
	localparam int RDY_ON     = 0;
	localparam int RDY_RANDOM = 1;
	localparam int RDY_LOW    = 2;
	// Preamble variants
	localparam int PRE_OK        = 0;
	localparam int PRE_BAD_FIRST = 1;
	localparam int PRE_SHORT     = 2;

	// One expected output word
	typedef struct packed {
		axis_meta_t              meta;
		logic [AXIS_BYTES*8-1:0] data;
	} exp_word_t;

	logic                    eth_clk = 1'b0;
	logic                    eth_sresetn;
	gmii_rx_t                gmii;
	logic                    out_valid;
	logic [AXIS_BYTES*8-1:0] out_data;
	axis_meta_t              out_meta;
	logic                    out_ready;
	logic [STAT_WIDTH-1:0]   good_frames;
	logic [STAT_WIDTH-1:0]   phy_err_frames;
	logic [STAT_WIDTH-1:0]   overflow_frames;
	logic [STAT_WIDTH-1:0]   preamble_errs;

	exp_word_t   exp_q [$];
	logic [7:0]  payload [0:127];
	logic [15:0] lfsr;
	int          ready_mode;
	int unsigned bytes_sent;
	int unsigned errors;
	// Tallies kept by the generator
	int unsigned n_good;
	int unsigned n_phy;
	int unsigned n_ovf;
	int unsigned n_pre;

	gmii_rx_mac #(
		.AXIS_BYTES      (AXIS_BYTES),
		.FIFO_DEPTH_LOG2 (FIFO_DEPTH_LOG2)
	) i_gmii_rx_mac (
		.eth_clk         (eth_clk),
		.eth_sresetn     (eth_sresetn),
		.gmii            (gmii),
		.out_valid       (out_valid),
		.out_data        (out_data),
		.out_meta        (out_meta),
		.out_ready       (out_ready),
		.good_frames     (good_frames),
		.phy_err_frames  (phy_err_frames),
		.overflow_frames (overflow_frames),
		.preamble_errs   (preamble_errs)
	);

	always #10 eth_clk = ~eth_clk;

	task automatic abort_run();
		$display("FAIL: see errors above");
		$fatal(1);
	endtask

	task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
		if (got !== exp)
		begin
			errors++;
			$display("[FAIL] t=%0t %s got 0x%0h expected 0x%0h", $time, name, got, exp);
			abort_run();
		end
	endtask

	// Galois LFSR, x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		lfsr_next = s >> 1;
		if (s[0])
			lfsr_next = lfsr_next ^ 16'hB400;
	endfunction

	// One LFSR step per bit taken
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < n; i++)
		begin
			lfsr = lfsr_next(lfsr);
			r = {r[30:0], lfsr[0]};
		end
		return r;
	endfunction

	function automatic int rand_range(input int lo, input int hi);
		return lo + int'(rand_bits(16) % (hi - lo + 1));
	endfunction

	// Word idx of a payload of len bytes, lane 0 holds the earliest byte, zeros above nbytes
	function automatic exp_word_t ref_word(input int len, input int idx);
		exp_word_t w;
		int        base;
		int        cnt;
		w    = '0;
		base = idx * AXIS_BYTES;
		cnt  = len - base;
		if (cnt > AXIS_BYTES)
			cnt = AXIS_BYTES;
		for (int b = 0; b < cnt; b++)
			w.data[b*8 +: 8] = payload[base + b];
		w.meta.nbytes = 4'(cnt);
		w.meta.last   = (base + cnt == len);
		return w;
	endfunction

	// Next falling edge, out_ready follows the current pattern
	task automatic tick();
		@(negedge eth_clk);
		case (ready_mode)
			RDY_ON:     out_ready = 1'b1;
			RDY_RANDOM: out_ready = (rand_bits(1) != 0);
			default:    out_ready = 1'b0;
		endcase
	endtask

	task automatic drive_byte(input logic [7:0] b, input logic er);
		tick();
		gmii = '{rxd: b, rxdv: 1'b1, rxer: er};
		bytes_sent++;
	endtask

	task automatic drive_idle(input int n);
		repeat (n)
		begin
			tick();
			gmii = '{rxd: 8'h00, rxdv: 1'b0, rxer: 1'b0};
		end
	endtask

	// err_idx below zero means a clean payload
	task automatic send_frame(input int len, input int err_idx, input int pre_kind);
		int n;
		n = (len + AXIS_BYTES - 1) / AXIS_BYTES;
		for (int i = 0; i < len; i++)
			payload[i] = 8'(rand_bits(8));
		if (pre_kind != PRE_OK)
			n_pre++;
		else if (err_idx >= 0)
			n_phy++;
		else
		begin
			// Hold the line idle until the frame fits, unless overflow is wanted
			if (ready_mode != RDY_LOW)
				while (exp_q.size() + n > DEPTH)
					tick();
			// Counts pending words, the output register's extra slot is left as margin
			if (exp_q.size() + n <= DEPTH)
			begin
				for (int k = 0; k < n; k++)
					exp_q.push_back(ref_word(len, k));
				n_good++;
			end
			else
				n_ovf++;
		end
		if (pre_kind == PRE_SHORT)
			repeat (4)
				drive_byte(8'h55, 1'b0);
		else
		begin
			if (pre_kind == PRE_BAD_FIRST)
				drive_byte(8'h47, 1'b0);
			repeat (7)
				drive_byte(8'h55, 1'b0);
			drive_byte(8'hD5, 1'b0);
			for (int i = 0; i < len; i++)
				drive_byte(payload[i], i == err_idx);
		end
		drive_idle(12);
	endtask

	task automatic drain();
		while (exp_q.size() != 0)
			tick();
		drive_idle(16);
		check("out_valid", 64'(out_valid), 64'(0));
	endtask

	task automatic check_counters();
		check("good_frames", 64'(good_frames), 64'(n_good));
		check("phy_err_frames", 64'(phy_err_frames), 64'(n_phy));
		check("overflow_frames", 64'(overflow_frames), 64'(n_ovf));
		check("preamble_errs", 64'(preamble_errs), 64'(n_pre));
	endtask

	// Compare on every output transfer
	always @(posedge eth_clk)
	begin
		exp_word_t e;
		if (eth_sresetn && out_valid && out_ready)
		begin
			if (exp_q.size() == 0)
			begin
				$display("Output word at time %0t arrived with no frame expected", $time);
				abort_run();
			end
			else
			begin
				e = exp_q.pop_front();
				check("out_data", 64'(out_data), 64'(e.data));
				check("out_meta.nbytes", 64'(out_meta.nbytes), 64'(e.meta.nbytes));
				check("out_meta.last", 64'(out_meta.last), 64'(e.meta.last));
			end
		end
	end

	// Budget grows with the bytes sent
	initial
	begin
		int unsigned cycles;
		cycles = 0;
		while (cycles <= bytes_sent * 40 + WATCHDOG_MARGIN)
		begin
			@(posedge eth_clk);
			cycles++;
		end
		$display("Watchdog expired after %0d cycles, the test stopped making progress", cycles);
		abort_run();
	end

	initial
	begin
		int len;
		eth_sresetn = 1'b0;
		gmii        = '{rxd: 8'h00, rxdv: 1'b0, rxer: 1'b0};
		out_ready   = 1'b0;
		ready_mode  = RDY_ON;
		lfsr        = SEED;
		bytes_sent  = 0;
		errors      = 0;
		n_good      = 0;
		n_phy       = 0;
		n_ovf       = 0;
		n_pre       = 0;
		repeat (16)
			tick();
		eth_sresetn = 1'b1;
		drive_idle(2);
		check("out_valid", 64'(out_valid), 64'(0));
		check_counters();

		// Every length from one byte up, partial last words included
		for (int l = 1; l <= 70; l++)
			send_frame(l, -1, PRE_OK);
		drain();
		check_counters();

		// rxer on one payload byte, clean frames around it
		repeat (4)
		begin
			send_frame(rand_range(1, 70), -1, PRE_OK);
			len = rand_range(1, 70);
			send_frame(len, rand_range(0, len - 1), PRE_OK);
		end
		send_frame(rand_range(1, 70), -1, PRE_OK);
		drain();
		check_counters();

		send_frame(rand_range(1, 70), -1, PRE_BAD_FIRST);
		send_frame(rand_range(1, 70), -1, PRE_OK);
		send_frame(0, -1, PRE_SHORT);
		send_frame(rand_range(1, 70), -1, PRE_OK);
		drain();
		check_counters();

		ready_mode = RDY_RANDOM;
		repeat (40)
			send_frame(rand_range(1, 70), -1, PRE_OK);
		ready_mode = RDY_ON;
		drain();
		check_counters();

		// 15-word frames, four fit and the last two find the FIFO full
		ready_mode = RDY_LOW;
		drive_idle(2);
		repeat (6)
			send_frame(60, -1, PRE_OK);
		ready_mode = RDY_ON;
		drain();
		check_counters();

		if (errors == 0)
		begin
			$display("PASS: all tests");
			$finish;
		end
		else
			abort_run();
	end

endmodule

`default_nettype wire

/* hw/gmii_rx_mac.sv */
// Gigabit GMII receive front end on one clock; no FCS check, no length limits, no MDIO
`default_nettype none

module gmii_rx_mac
#(
	parameter int unsigned AXIS_BYTES      = 4,
	parameter int unsigned FIFO_DEPTH_LOG2 = 6
)
(
	input  wire                                eth_clk,
	input  wire                                eth_sresetn,

	input  wire gmii_rx_pkg::gmii_rx_t         gmii,

	output logic                               out_valid,
	output logic [AXIS_BYTES*8-1:0]            out_data,
	output gmii_rx_pkg::axis_meta_t            out_meta,
	input  wire                                out_ready,

	output logic [gmii_rx_pkg::STAT_WIDTH-1:0] good_frames,
	output logic [gmii_rx_pkg::STAT_WIDTH-1:0] phy_err_frames,
	output logic [gmii_rx_pkg::STAT_WIDTH-1:0] overflow_frames,
	output logic [gmii_rx_pkg::STAT_WIDTH-1:0] preamble_errs
);

	import gmii_rx_pkg::*;

	// Framer to FIFO, plain strobe with no back-pressure
	logic                    wr_valid;
	logic [AXIS_BYTES*8-1:0] wr_data;
	axis_meta_t              wr_meta;
	logic                    wr_error;

	// Status strobes to the counters
	frame_event_t            preamble_event;
	frame_event_t            frame_event;

	gmii_rx_framer #(
		.AXIS_BYTES(AXIS_BYTES)
	) i_gmii_rx_framer (
		.eth_clk        (eth_clk),
		.eth_sresetn    (eth_sresetn),
		.gmii           (gmii),
		.wr_valid       (wr_valid),
		.wr_data        (wr_data),
		.wr_meta        (wr_meta),
		.wr_error       (wr_error),
		.preamble_event (preamble_event)
	);

	rx_packet_fifo #(
		.AXIS_BYTES      (AXIS_BYTES),
		.FIFO_DEPTH_LOG2 (FIFO_DEPTH_LOG2)
	) i_rx_packet_fifo (
		.eth_clk     (eth_clk),
		.eth_sresetn (eth_sresetn),
		.wr_valid    (wr_valid),
		.wr_data     (wr_data),
		.wr_meta     (wr_meta),
		.wr_error    (wr_error),
		.frame_event (frame_event),
		.out_valid   (out_valid),
		.out_data    (out_data),
		.out_meta    (out_meta),
		.out_ready   (out_ready)
	);

	rx_frame_stats i_rx_frame_stats (
		.eth_clk         (eth_clk),
		.eth_sresetn     (eth_sresetn),
		.preamble_event  (preamble_event),
		.frame_event     (frame_event),
		.good_frames     (good_frames),
		.phy_err_frames  (phy_err_frames),
		.overflow_frames (overflow_frames),
		.preamble_errs   (preamble_errs)
	);

endmodule

`default_nettype wire

/* hw/rx_frame_stats.sv */
// Counters stick at all ones and clear only on reset
`default_nettype none

module rx_frame_stats
(
	input  wire                                  eth_clk,
	input  wire                                  eth_sresetn,

	input  wire gmii_rx_pkg::frame_event_t       preamble_event,
	input  wire gmii_rx_pkg::frame_event_t       frame_event,

	output logic [gmii_rx_pkg::STAT_WIDTH-1:0]   good_frames,
	output logic [gmii_rx_pkg::STAT_WIDTH-1:0]   phy_err_frames,
	output logic [gmii_rx_pkg::STAT_WIDTH-1:0]   overflow_frames,
	output logic [gmii_rx_pkg::STAT_WIDTH-1:0]   preamble_errs
);

	import gmii_rx_pkg::*;

	// One counter per frame_status_e value
	localparam int unsigned NUM_STATUS = 4;

	logic [STAT_WIDTH-1:0] count [NUM_STATUS];

	// Both events may land on the same status in one cycle
	function automatic logic [1:0] hits(input frame_event_t a, input frame_event_t b,
		input frame_status_e st);
		hits = {1'b0, a.valid && (a.status == st)} + {1'b0, b.valid && (b.status == st)};
	endfunction

	for (genvar i = 0; i < NUM_STATUS; i++)
	begin : g_counter
		logic [1:0]          inc;
		logic [STAT_WIDTH:0] sum;

		assign inc = hits(preamble_event, frame_event, frame_status_e'(i));
		// Carry out of the sum means saturate
		assign sum = {1'b0, count[i]} + {{(STAT_WIDTH-1){1'b0}}, inc};

		always_ff @(posedge eth_clk)
		begin
			if (!eth_sresetn)
				count[i] <= '0;
			else if (sum[STAT_WIDTH])
				count[i] <= '1;
			else
				count[i] <= sum[STAT_WIDTH-1:0];
		end
	end

	// Framer reports only preamble aborts, the FIFO never does
	a_event_sources: assert property (@(posedge eth_clk) disable iff (!eth_sresetn)
		(!preamble_event.valid || (preamble_event.status == ST_PREAMBLE_ERR)) &&
		(!frame_event.valid || (frame_event.status != ST_PREAMBLE_ERR)));

	assign good_frames     = count[ST_GOOD];
	assign phy_err_frames  = count[ST_PHY_ERR];
	assign overflow_frames = count[ST_OVERFLOW];
	assign preamble_errs   = count[ST_PREAMBLE_ERR];

endmodule

`default_nettype wire

/* hw/rx_packet_fifo.sv */
// Single clock; only whole error-free frames reach the output, frames that do not fit are dropped
`default_nettype none

module rx_packet_fifo
#(
	parameter int unsigned AXIS_BYTES      = 4,
	parameter int unsigned FIFO_DEPTH_LOG2 = 6
)
(
	input  wire                       eth_clk,
	input  wire                       eth_sresetn,

	input  wire                       wr_valid,
	input  wire [AXIS_BYTES*8-1:0]    wr_data,
	input  wire gmii_rx_pkg::axis_meta_t wr_meta,
	input  wire                       wr_error,

	output gmii_rx_pkg::frame_event_t frame_event,

	output logic                      out_valid,
	output logic [AXIS_BYTES*8-1:0]   out_data,
	output gmii_rx_pkg::axis_meta_t   out_meta,
	input  wire                       out_ready
);

	import gmii_rx_pkg::*;

	localparam int unsigned DEPTH = 1 << FIFO_DEPTH_LOG2;
	// Extra bit tells full from empty
	localparam int unsigned PTR_W = FIFO_DEPTH_LOG2 + 1;

	if ((AXIS_BYTES < 1) || (AXIS_BYTES > MAX_AXIS_BYTES))
	begin : g_width_check
		$error("AXIS_BYTES must lie between 1 and %0d", MAX_AXIS_BYTES);
	end

	// Stored entry, sideband kept alongside the data
	typedef struct packed {
		axis_meta_t              meta;
		logic [AXIS_BYTES*8-1:0] data;
	} fifo_word_t;

	fifo_word_t       mem [DEPTH];
	fifo_word_t       rd_word;
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] wr_ptr_inc;
	logic [PTR_W-1:0] commit_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic             full;
	logic             word_fits;
	logic             ovf_flag;
	logic             frame_ovf;
	logic             commit_avail;
	logic             load_out;

	// Space is counted against the read pointer, uncommitted words also take room
	assign full       = (wr_ptr - rd_ptr) == PTR_W'(DEPTH);
	assign word_fits  = wr_valid && !ovf_flag && !full;
	assign wr_ptr_inc = wr_ptr + 1'b1;
	// Frame overflowed earlier or its current word finds no room
	assign frame_ovf  = ovf_flag || full;

	always_ff @(posedge eth_clk)
	begin
		if (word_fits)
			mem[wr_ptr[FIFO_DEPTH_LOG2-1:0]] <= '{meta: wr_meta, data: wr_data};
	end

	// Write side, tentative pointer with commit or rewind at frame end
	always_ff @(posedge eth_clk)
	begin
		if (!eth_sresetn)
		begin
			wr_ptr      <= '0;
			commit_ptr  <= '0;
			ovf_flag    <= 1'b0;
			frame_event <= '{valid: 1'b0, status: ST_GOOD};
		end
		else
		begin
			frame_event.valid <= 1'b0;
			if (wr_valid)
			begin
				if (wr_meta.last)
				begin
					ovf_flag          <= 1'b0;
					frame_event.valid <= 1'b1;
					// PHY error wins over overflow
					if (wr_error)
					begin
						frame_event.status <= ST_PHY_ERR;
						wr_ptr             <= commit_ptr;
					end
					else if (frame_ovf)
					begin
						frame_event.status <= ST_OVERFLOW;
						wr_ptr             <= commit_ptr;
					end
					else
					begin
						// Closing word is written this cycle and included in the commit
						frame_event.status <= ST_GOOD;
						wr_ptr             <= wr_ptr_inc;
						commit_ptr         <= wr_ptr_inc;
					end
				end
				else if (word_fits)
					wr_ptr <= wr_ptr_inc;
				else
					// Rest of the frame is discarded until its last word
					ovf_flag <= 1'b1;
			end
		end
	end

	// Read side only ever sees committed words
	assign rd_word      = mem[rd_ptr[FIFO_DEPTH_LOG2-1:0]];
	assign commit_avail = (rd_ptr != commit_ptr);
	assign load_out     = commit_avail && (!out_valid || out_ready);

	always_ff @(posedge eth_clk)
	begin
		if (!eth_sresetn)
		begin
			rd_ptr    <= '0;
			out_valid <= 1'b0;
		end
		else if (load_out)
		begin
			rd_ptr    <= rd_ptr + 1'b1;
			out_valid <= 1'b1;
		end
		else if (out_ready)
			out_valid <= 1'b0;
	end

	// Output register refilled on transfer or when empty
	always_ff @(posedge eth_clk)
	begin
		if (load_out)
		begin
			out_data <= rd_word.data;
			out_meta <= rd_word.meta;
		end
	end

	// Stream holds its word until the sink takes it
	a_out_stable: assert property (@(posedge eth_clk) disable iff (!eth_sresetn)
		(out_valid && !out_ready) |=> (out_valid && $stable(out_data) && $stable(out_meta)));

	// Reader stays behind the commit point
	a_rd_behind_commit: assert property (@(posedge eth_clk) disable iff (!eth_sresetn)
		PTR_W'(commit_ptr - rd_ptr) <= PTR_W'(DEPTH));

endmodule

`default_nettype wire

/* hw/gmii_rx_framer.sv */
// No flow control on either side; the first valid byte after idle must start the preamble
`default_nettype none

module gmii_rx_framer
#(
	parameter int unsigned AXIS_BYTES = 4
)
(
	input  wire                        eth_clk,
	input  wire                        eth_sresetn,

	input  wire gmii_rx_pkg::gmii_rx_t gmii,

	output logic                       wr_valid,
	output logic [AXIS_BYTES*8-1:0]    wr_data,
	output gmii_rx_pkg::axis_meta_t    wr_meta,
	output logic                       wr_error,

	output gmii_rx_pkg::frame_event_t  preamble_event
);

	import gmii_rx_pkg::*;

	localparam int unsigned LANE_W = (AXIS_BYTES > 1) ? $clog2(AXIS_BYTES) : 1;
	localparam logic [LANE_W-1:0] LANE_MAX = LANE_W'(AXIS_BYTES - 1);
	localparam logic [7:0] PREAMBLE_BYTE = 8'h55;
	localparam logic [7:0] SFD_BYTE = 8'hD5;

	if ((AXIS_BYTES < 1) || (AXIS_BYTES > MAX_AXIS_BYTES))
	begin : g_width_check
		$error("AXIS_BYTES must lie between 1 and %0d", MAX_AXIS_BYTES);
	end

	gmii_rx_t          rx_q;
	logic              rx_last;
	framer_state_e     state;
	logic [LANE_W-1:0] lane;
	logic              err_sticky;
	logic              word_done;

	// Pins registered once, the byte is examined one cycle after sampling
	always_ff @(posedge eth_clk)
	begin
		if (!eth_sresetn)
			rx_q <= '0;
		else
			rx_q <= gmii;
	end

	// Live rxdv low means the registered byte closes the frame
	assign rx_last = !gmii.rxdv;
	// Word is emitted when its top lane fills or the frame ends
	assign word_done = (lane == LANE_MAX) || rx_last;

	always_ff @(posedge eth_clk)
	begin
		if (!eth_sresetn)
		begin
			state          <= FR_WAIT_IDLE;
			lane           <= '0;
			err_sticky     <= 1'b0;
			wr_valid       <= 1'b0;
			wr_error       <= 1'b0;
			preamble_event <= '{valid: 1'b0, status: ST_PREAMBLE_ERR};
		end
		else
		begin
			// Strobes default low
			wr_valid             <= 1'b0;
			wr_error             <= 1'b0;
			preamble_event.valid <= 1'b0;

			case (state)
				FR_WAIT_IDLE:
				begin
					// Need one idle cycle before a new preamble can start
					if (!rx_q.rxdv)
						state <= FR_PREAMBLE;
				end

				FR_PREAMBLE:
				begin
					if (rx_q.rxdv)
					begin
						if (rx_q.rxd == PREAMBLE_BYTE)
							state <= FR_SFD;
						else
						begin
							// Bad first byte, drop the rest of this burst
							preamble_event.valid <= 1'b1;
							state                <= FR_WAIT_IDLE;
						end
					end
				end

				FR_SFD:
				begin
					if (!rx_q.rxdv)
					begin
						// Burst ended inside the preamble; line is already idle
						preamble_event.valid <= 1'b1;
						state                <= FR_PREAMBLE;
					end
					else if (rx_q.rxd == SFD_BYTE)
					begin
						lane       <= '0;
						err_sticky <= 1'b0;
						// SFD with no payload behind it writes nothing
						state      <= rx_last ? FR_PREAMBLE : FR_PAYLOAD;
					end
					else if (rx_q.rxd != PREAMBLE_BYTE)
					begin
						preamble_event.valid <= 1'b1;
						state                <= FR_WAIT_IDLE;
					end
				end

				FR_PAYLOAD:
				begin
					// rxdv is always high here, the state is left on the last byte
					wr_valid <= word_done;
					if (word_done)
						lane <= '0;
					else
						lane <= lane + 1'b1;
					// Error flag only goes out with the closing word
					wr_error   <= rx_last && (err_sticky || rx_q.rxer);
					err_sticky <= !rx_last && (err_sticky || rx_q.rxer);
					if (rx_last)
						state <= FR_PREAMBLE;
				end

				default:
					state <= FR_WAIT_IDLE;
			endcase
		end
	end

	// Packing register doubles as the write word
	always_ff @(posedge eth_clk)
	begin
		if (state == FR_PAYLOAD)
		begin
			// Clear stale lanes so partial words carry zeros above nbytes
			if (lane == '0)
				wr_data <= '0;
			wr_data[lane*8 +: 8] <= rx_q.rxd;
			if (word_done)
			begin
				wr_meta.last   <= rx_last;
				wr_meta.nbytes <= 4'(lane) + 4'd1;
			end
		end
	end

	// Error must reach the FIFO on the closing word or the frame gets committed
	a_error_on_last: assert property (@(posedge eth_clk) disable iff (!eth_sresetn)
		wr_error |-> (wr_valid && wr_meta.last));

	// Every emitted word holds between one and AXIS_BYTES bytes
	a_nbytes_range: assert property (@(posedge eth_clk) disable iff (!eth_sresetn)
		wr_valid |-> ((wr_meta.nbytes != 4'd0) && (wr_meta.nbytes <= AXIS_BYTES)));

endmodule

`default_nettype wire

/* hw/gmii_rx_pkg.sv */
// Shared receive path types; gigabit GMII only, output words hold at most MAX_AXIS_BYTES bytes
`default_nettype none

package gmii_rx_pkg;

	// Receive pins of the PHY, all sampled on eth_clk
	typedef struct packed {
		logic [7:0] rxd;
		logic       rxdv;
		logic       rxer;
	} gmii_rx_t;

	// Widest word that nbytes below can describe
	localparam int unsigned MAX_AXIS_BYTES = 8;

	// Sideband of one packed word
	// Valid bytes always start at lane 0, the first byte received
	typedef struct packed {
		logic       last;
		logic [3:0] nbytes;
	} axis_meta_t;

	// Preamble stripping and packing states
	typedef enum logic [1:0] {
		FR_WAIT_IDLE,
		FR_PREAMBLE,
		FR_SFD,
		FR_PAYLOAD
	} framer_state_e;

	// Reason a frame ended, also the index of its statistics counter
	typedef enum logic [1:0] {
		ST_GOOD,
		ST_PHY_ERR,
		ST_OVERFLOW,
		ST_PREAMBLE_ERR
	} frame_status_e;

	// One-cycle strobe reporting the end of a frame
	typedef struct packed {
		logic          valid;
		frame_status_e status;
	} frame_event_t;

	// Width of each saturating statistics counter
	localparam int unsigned STAT_WIDTH = 16;

endpackage

`default_nettype wire
